/* files.f */
+incdir+rtl
rtl/regs_pkg.sv
rtl/reg_sel_if.sv
rtl/bank_decode.sv
rtl/reg_array.sv
rtl/cpu_regs.sv
tb/cpu_regs_checker.sv
tb/cpu_regs_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= cpu_regs_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Verification passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* tb/cpu_regs_tb.sv */
// directed testbench for the CPU register file against a byte-level model
`timescale 1ns/1ps
`default_nettype none
`include "regs_params.svh"

module cpu_regs_tb import regs_pkg::*; ();

    localparam int TIMEOUT = 2000;
    localparam int RFP_W   = $clog2(`REGS_BANKS);

    logic clk, rst, cen;
    logic inc_rfp, dec_rfp, rfp_we, idx_en;
    logic [RFP_W-1:0] imm, rfp;
    reg_code_t src, dst, idx_rdreg_sel, idx_rdreg_aux;
    step_t reg_step;
    logic reg_inc, reg_dec, inc_xde, dec_xde, inc_xix, dec_xix, dec_bc;
    logic [15:0] inc_xsp, sr;
    logic [2:0] dec_xsp;
    logic [31:0] alu_dout, ram_dout;
    logic data_sel, flag_only, ld_high;
    wr_size_t alu_we, ram_we;
    logic [7:0] dmp_addr, dmp_din;
    logic [31:0] src_out, aux_out, dst_out, acc, xsp;
    logic bc_unity;

    // model of the 64 general bytes, 16 pointer bytes and the bank pointer
    logic [7:0] m_gen [0:`REGS_BANKS*`REGS_BANK_BYTES-1];
    logic [7:0] m_ptr [0:`REGS_PTR_BYTES-1];
    logic [RFP_W-1:0] m_rfp;
    integer seed;
    int cycles = 0;

    cpu_regs UUT (.*);

    bind reg_array cpu_regs_checker u_chk (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .rfp      (bank),
        .bc_word  ({gen_q[{bank, 4'd5}], gen_q[{bank, 4'd4}]}),
        .bc_unity (bc_unity),
        .dmp_addr (dmp_addr),
        .gen_byte (gen_q[dmp_addr[5:0]]),
        .ptr_byte (ptr_q[dmp_addr[3:0]]),
        .dmp_din  (dmp_din)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("timeout: tests did not finish within %0d cycles", TIMEOUT);
            $display("Verification failed");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    // E names the current bank, D the one below it
    function automatic logic [7:0] phys(input logic [7:0] c);
        logic [7:0] p;
        logic [RFP_W-1:0] prev;
        p = c;
        prev = m_rfp - RFP_W'(1);
        if (c[7:4] == `REGS_CURBANK) begin
            p[7:4] = 4'(m_rfp);
        end else if (c[7:4] == `REGS_PREVBANK) begin
            p[7:4] = 4'(prev);
        end
        return p;
    endfunction

    function automatic logic [7:0] fetch_byte(input logic [7:0] p);
        return p[7] ? m_ptr[p[3:0]] : m_gen[p[5:0]];
    endfunction

    task automatic poke_byte(input logic [7:0] p, input logic [7:0] v);
        if (p[7]) begin
            m_ptr[p[3:0]] = v;
        end else begin
            m_gen[p[5:0]] = v;
        end
    endtask

    task automatic store_long(input logic [7:0] p, input logic [31:0] v);
        for (int i = 0; i < 4; i++) begin
            poke_byte({p[7:2], 2'(i)}, v[8*i +: 8]);
        end
    endtask

    // little endian with the lowest byte from the exact code
    function automatic logic [31:0] model_read(input logic [7:0] c, input logic src_port);
        logic [7:0] p;
        p = phys(c);
        if (src_port && p[7:4] == 4'h4) begin
            return 32'd0;
        end
        return {fetch_byte({p[7:2], 2'd3}), fetch_byte({p[7:2], 2'd2}),
                fetch_byte({p[7:1], 1'b1}), fetch_byte(p)};
    endfunction

    function automatic logic [31:0] step_size(input step_t code);
        if (code == 2'd1) begin
            return 32'd2;
        end
        if (code == 2'd2) begin
            return 32'd4;
        end
        return 32'd1;
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s expected %h actual %h", name, expected, actual);
            $display("Verification failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic set_idle();
        inc_rfp <= 1'b0;
        dec_rfp <= 1'b0;
        rfp_we <= 1'b0;
        reg_inc <= 1'b0;
        reg_dec <= 1'b0;
        inc_xde <= 1'b0;
        dec_xde <= 1'b0;
        inc_xix <= 1'b0;
        dec_xix <= 1'b0;
        dec_bc <= 1'b0;
        inc_xsp <= 16'd0;
        dec_xsp <= 3'd0;
        alu_we <= 3'd0;
        ram_we <= 3'd0;
        flag_only <= 1'b0;
        ld_high <= 1'b0;
    endtask

    // capture edge of a one-cycle strobe
    task automatic finish_op();
        @(posedge clk);
        set_idle();
    endtask

    task automatic read_check(input string name, input logic [7:0] code);
        @(posedge clk);
        src <= code;
        dst <= code;
        @(negedge clk);
        check({name, " src"}, model_read(code, 1'b1), src_out);
        check({name, " dst"}, model_read(code, 1'b0), dst_out);
    endtask

    task automatic write_reg(input logic [7:0] code, input logic [31:0] data,
                             input logic [2:0] size, input logic from_ram,
                             input logic high, input logic fonly);
        logic [7:0] p;
        p = phys(code);
        @(posedge clk);
        dst <= code;
        data_sel <= from_ram;
        alu_dout <= from_ram ? ~data : data;
        ram_dout <= from_ram ? data : ~data;
        alu_we <= from_ram ? 3'd0 : size;
        ram_we <= from_ram ? size : 3'd0;
        ld_high <= high;
        flag_only <= fonly;
        if (!fonly) begin
            if (size[2]) begin
                store_long(p, data);
            end else if (size[1]) begin
                poke_byte(p, data[7:0]);
                poke_byte({p[7:1], 1'b1}, data[15:8]);
            end else begin
                poke_byte(p, (high && !p[7]) ? data[15:8] : data[7:0]);
            end
        end
        finish_op();
    endtask

    task automatic bank_op(input logic ld, input logic inc, input logic dec,
                           input logic [RFP_W-1:0] val);
        @(posedge clk);
        rfp_we <= ld;
        inc_rfp <= inc;
        dec_rfp <= dec;
        imm <= val;
        if (ld) begin
            m_rfp = val;
        end else if (dec) begin
            m_rfp = m_rfp - RFP_W'(1);
        end else if (inc) begin
            m_rfp = m_rfp + RFP_W'(1);
        end
        finish_op();
        @(negedge clk);
        check("rfp", 32'(m_rfp), 32'(rfp));
    endtask

    task automatic step_reg(input logic [7:0] code, input step_t st, input logic down);
        logic [7:0] p;
        logic [31:0] v;
        p = phys(code);
        v = model_read({p[7:2], 2'b00}, 1'b0);
        @(posedge clk);
        src <= code;
        dst <= code;
        reg_step <= st;
        reg_inc <= !down;
        reg_dec <= down;
        @(negedge clk);
        if (down) begin
            check("pre-decrement dst", model_read(code, 1'b0) - step_size(st), dst_out);
        end
        store_long(p, down ? v - step_size(st) : v + step_size(st));
        finish_op();
    endtask

    task automatic step_ptrs(input step_t st, input logic up);
        logic [31:0] de;
        logic [31:0] ix;
        de = model_read(8'hE8, 1'b0);
        ix = model_read(8'h80, 1'b0);
        @(posedge clk);
        reg_step <= st;
        inc_xde <= up;
        dec_xde <= !up;
        inc_xix <= up;
        dec_xix <= !up;
        store_long(phys(8'hE8), up ? de + step_size(st) : de - step_size(st));
        store_long(8'h80, up ? ix + step_size(st) : ix - step_size(st));
        finish_op();
    endtask

    task automatic stack_op(input logic [15:0] inc_amt, input logic [2:0] dec_amt);
        logic [31:0] sp;
        sp = model_read(8'h8C, 1'b0);
        @(posedge clk);
        inc_xsp <= inc_amt;
        dec_xsp <= dec_amt;
        store_long(8'h8C, (inc_amt != 16'd0) ? sp + 32'(inc_amt) : sp - 32'(dec_amt));
        finish_op();
        @(negedge clk);
        check("xsp", model_read(8'h8C, 1'b0), xsp);
    endtask

    task automatic count_bc_down();
        logic [15:0] bc;
        bc = {fetch_byte(phys(8'hE5)), fetch_byte(phys(8'hE4))} - 16'd1;
        @(posedge clk);
        src <= 8'hE4;
        dec_bc <= 1'b1;
        poke_byte(phys(8'hE4), bc[7:0]);
        poke_byte(phys(8'hE5), bc[15:8]);
        finish_op();
    endtask

    task automatic writeback_test();
        logic [31:0] n;
        logic [31:0] data;
        logic [7:0] code;
        logic [2:0] size;
        for (int i = 0; i < 16; i++) begin
            n = $random(seed);
            data = $random(seed);
            size = (n[1:0] == 2'd0) ? 3'b100 : (n[1:0] == 2'd1) ? 3'b010 : 3'b001;
            code = (i % 4 == 3) ? {4'h8, n[7:4]} : {2'b00, n[9:4]};
            if (size[2]) begin
                code[1:0] = 2'b00;
            end else if (size[1]) begin
                code[0] = 1'b0;
            end
            write_reg(code, data, size, data[3], data[9], 1'b0);
            read_check("write-back", code);
        end
        // flag-only ALU result must not land
        write_reg(8'h00, 32'hdeadbeef, 3'b100, 1'b0, 1'b0, 1'b1);
        read_check("flag only", 8'h00);
    endtask

    task automatic bank_test();
        logic [31:0] v;
        v = $random(seed);
        bank_op(1'b1, 1'b0, 1'b0, 2'd2);
        write_reg(8'hE0, v, 3'b100, 1'b0, 1'b0, 1'b0);
        @(negedge clk);
        check("acc bank 2", v, acc);
        bank_op(1'b0, 1'b1, 1'b0, 2'd0);
        read_check("previous bank", 8'hD0);
        check("acc bank 3", model_read(8'h30, 1'b0), acc);
        bank_op(1'b0, 1'b1, 1'b0, 2'd0);
        bank_op(1'b0, 1'b0, 1'b1, 2'd0);
        bank_op(1'b0, 1'b1, 1'b1, 2'd0);
        bank_op(1'b1, 1'b1, 1'b1, 2'd1);
        read_check("zero source", 8'h42);
        // index addressing overrides src and dst
        @(posedge clk);
        idx_en <= 1'b1;
        idx_rdreg_sel <= 8'hEC;
        idx_rdreg_aux <= 8'hD8;
        @(negedge clk);
        check("index src", model_read(8'hEC, 1'b1), src_out);
        check("index aux", model_read(8'hE8, 1'b1), aux_out);
        check("index dst", model_read(8'hD8, 1'b0), dst_out);
        @(posedge clk);
        idx_en <= 1'b0;
    endtask

    task automatic step_test();
        for (int s = 0; s < 4; s++) begin
            step_reg(8'h84, 2'(s), 1'b0);
            read_check("step up", 8'h84);
            step_reg(8'hE0, 2'(s), 1'b1);
            read_check("step down", 8'hE0);
            step_ptrs(2'(s), s[0]);
            read_check("xde step", 8'hE8);
            read_check("xix step", 8'h80);
        end
    endtask

    task automatic stack_test();
        stack_op(16'h0100, 3'd0);
        stack_op(16'd0, 3'd4);
        stack_op(16'd0, 3'd2);
        stack_op(16'h0006, 3'd0);
    endtask

    task automatic bc_test();
        write_reg(8'hE4, 32'd3, 3'b010, 1'b0, 1'b0, 1'b0);
        count_bc_down();
        count_bc_down();
        @(negedge clk);
        check("bc at one", model_read(8'hE4, 1'b1), src_out);
        check("bc_unity low", 32'd0, 32'(bc_unity));
        @(posedge clk);
        @(negedge clk);
        check("bc_unity high", 32'd1, 32'(bc_unity));
        // strobes with cen low must change nothing
        @(posedge clk);
        cen <= 1'b0;
        dst <= 8'hE0;
        alu_dout <= 32'h12345678;
        data_sel <= 1'b0;
        alu_we <= 3'b100;
        inc_rfp <= 1'b1;
        dec_bc <= 1'b1;
        inc_xsp <= 16'h0010;
        repeat (3) @(posedge clk);
        set_idle();
        cen <= 1'b1;
        @(negedge clk);
        check("freeze rfp", 32'(m_rfp), 32'(rfp));
        check("freeze bc_unity", 32'd1, 32'(bc_unity));
        check("freeze xsp", model_read(8'h8C, 1'b0), xsp);
        read_check("freeze xwa", 8'hE0);
        read_check("freeze bc", 8'hE4);
    endtask

    task automatic dump_test();
        logic [15:0] srv;
        logic [7:0] expected;
        srv = 16'($random(seed));
        @(posedge clk);
        sr <= srv;
        cen <= 1'b0;
        for (int a = 0; a < 'h56; a++) begin
            @(posedge clk);
            dmp_addr <= 8'(a);
            @(posedge clk);
            @(negedge clk);
            if (a < 'h40) begin
                expected = m_gen[6'(a)];
            end else if (a < 'h50) begin
                expected = m_ptr[4'(a - 'h40)];
            end else if (a == 'h50) begin
                expected = srv[15:8];
            end else if (a == 'h51) begin
                expected = srv[7:0];
            end else begin
                expected = 8'd0;
            end
            check("dump", 32'(expected), 32'(dmp_din));
        end
        @(posedge clk);
        cen <= 1'b1;
    endtask

    initial begin
        seed = 11;
        clk = 1'b0;
        rst = 1'b1;
        cen = 1'b1;
        imm = '0;
        idx_en = 1'b0;
        src = 8'h00;
        dst = 8'h00;
        idx_rdreg_sel = 8'h00;
        idx_rdreg_aux = 8'h00;
        reg_step = 2'd0;
        alu_dout = 32'd0;
        ram_dout = 32'd0;
        data_sel = 1'b0;
        dmp_addr = 8'h00;
        sr = 16'h0000;
        set_idle();
        m_rfp = '0;
        for (int i = 0; i < `REGS_BANKS * `REGS_BANK_BYTES; i++) begin
            m_gen[i] = 8'd0;
        end
        for (int i = 0; i < `REGS_PTR_BYTES; i++) begin
            m_ptr[i] = 8'd0;
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        writeback_test();
        bank_test();
        step_test();
        stack_test();
        bc_test();
        dump_test();

        if (UUT.u_array.u_chk.fail_count == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("checker reported %0d assertion failures", UUT.u_array.u_chk.fail_count);
            $display("Verification failed");
            $fatal(1, "assertion failures in the checker");
        end
    end

endmodule

`default_nettype wire

/* tb/cpu_regs_checker.sv */
// assertions on register array reset state, dump latency and the BC flag
`timescale 1ns/1ps
`default_nettype none
`include "regs_params.svh"

module cpu_regs_checker (
    input wire logic                           clk,
    input wire logic                           rst,
    input wire logic                           cen,
    input wire logic [$clog2(`REGS_BANKS)-1:0] rfp,
    input wire logic [15:0]                    bc_word,
    input wire logic                           bc_unity,
    input wire logic [7:0]                     dmp_addr,
    input wire logic [7:0]                     gen_byte,
    input wire logic [7:0]                     ptr_byte,
    input wire logic [7:0]                     dmp_din
);

    int fail_count = 0;

    // pointer and flag stay cleared while reset is held
    a_reset_state: assert property (@(posedge clk)
        (rst && $past(rst)) |-> (bc_unity == 1'b0 && rfp == '0))
        else begin
            fail_count++;
            $error("rfp or bc_unity not cleared during reset");
        end

    // general byte under the address shows up one clock later
    a_dump_gen: assert property (@(posedge clk) disable iff (rst)
        $past(dmp_addr < 8'h40) |-> (dmp_din == $past(gen_byte)))
        else begin
            fail_count++;
            $error("dump of a general byte does not follow the address one clock later");
        end

    // same for the pointer bytes at 40 to 4F
    a_dump_ptr: assert property (@(posedge clk) disable iff (rst)
        $past(dmp_addr[7:4] == 4'h4) |-> (dmp_din == $past(ptr_byte)))
        else begin
            fail_count++;
            $error("dump of a pointer byte does not follow the address one clock later");
        end

    // flag follows stored BC on enabled edges and holds otherwise
    a_bc_flag: assert property (@(posedge clk) disable iff (rst)
        bc_unity == ($past(cen) ? $past(bc_word == 16'd1) : $past(bc_unity)))
        else begin
            fail_count++;
            $error("bc_unity does not reflect BC equal to one");
        end

endmodule

`default_nettype wire

/* rtl/cpu_regs.sv */
// CPU register file top joining the bank decoder and the register array
`timescale 1ns/1ps
`default_nettype none
`include "regs_params.svh"

module cpu_regs import regs_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire logic      cen,
    // bank pointer control
    input  wire logic      inc_rfp,
    input  wire logic      dec_rfp,
    input  wire logic      rfp_we,
    input  wire logic [$clog2(`REGS_BANKS)-1:0] imm,
    output logic      [$clog2(`REGS_BANKS)-1:0] rfp,
    // operand codes
    input  wire logic      idx_en,
    input  wire reg_code_t src,
    input  wire reg_code_t dst,
    input  wire reg_code_t idx_rdreg_sel,
    input  wire reg_code_t idx_rdreg_aux,
    // auto-step and counters
    input  wire step_t     reg_step,
    input  wire logic      reg_inc,
    input  wire logic      reg_dec,
    input  wire logic      inc_xde,
    input  wire logic      dec_xde,
    input  wire logic      inc_xix,
    input  wire logic      dec_xix,
    input  wire logic      dec_bc,
    input  wire logic [15:0] inc_xsp,
    input  wire logic [2:0]  dec_xsp,
    // write-back
    input  wire logic [31:0] alu_dout,
    input  wire logic [31:0] ram_dout,
    input  wire logic      data_sel,
    input  wire wr_size_t  alu_we,
    input  wire wr_size_t  ram_we,
    input  wire logic      flag_only,
    input  wire logic      ld_high,
    // debug dump
    input  wire logic [7:0]  dmp_addr,
    input  wire logic [15:0] sr,
    output logic [31:0]    src_out,
    output logic [31:0]    aux_out,
    output logic [31:0]    dst_out,
    output logic [31:0]    acc,
    output logic [31:0]    xsp,
    output logic           bc_unity,
    output logic [7:0]     dmp_din
);

    reg_sel_if u_sel ();

    bank_decode u_dec (
        .clk           (clk),
        .rst           (rst),
        .cen           (cen),
        .inc_rfp       (inc_rfp),
        .dec_rfp       (dec_rfp),
        .rfp_we        (rfp_we),
        .imm           (imm),
        .idx_en        (idx_en),
        .src           (src),
        .dst           (dst),
        .idx_rdreg_sel (idx_rdreg_sel),
        .idx_rdreg_aux (idx_rdreg_aux),
        .sel           (u_sel),
        .rfp           (rfp)
    );

    reg_array u_array (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .sel       (u_sel),
        .reg_step  (reg_step),
        .reg_inc   (reg_inc),
        .reg_dec   (reg_dec),
        .inc_xde   (inc_xde),
        .dec_xde   (dec_xde),
        .inc_xix   (inc_xix),
        .dec_xix   (dec_xix),
        .dec_bc    (dec_bc),
        .inc_xsp   (inc_xsp),
        .dec_xsp   (dec_xsp),
        .alu_dout  (alu_dout),
        .ram_dout  (ram_dout),
        .data_sel  (data_sel),
        .alu_we    (alu_we),
        .ram_we    (ram_we),
        .flag_only (flag_only),
        .ld_high   (ld_high),
        .dmp_addr  (dmp_addr),
        .sr        (sr),
        .src_out   (src_out),
        .aux_out   (aux_out),
        .dst_out   (dst_out),
        .acc       (acc),
        .xsp       (xsp),
        .bc_unity  (bc_unity),
        .dmp_din   (dmp_din)
    );

endmodule

`default_nettype wire

/* rtl/reg_array.sv */
// register storage with read ports, write-back, auto-step, stack and dump
`timescale 1ns/1ps
`default_nettype none
`include "regs_params.svh"

module reg_array import regs_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     cen,
    reg_sel_if.array      sel,
    input  wire step_t    reg_step,
    input  wire logic     reg_inc,
    input  wire logic     reg_dec,
    input  wire logic     inc_xde,
    input  wire logic     dec_xde,
    input  wire logic     inc_xix,
    input  wire logic     dec_xix,
    input  wire logic     dec_bc,
    input  wire logic [15:0] inc_xsp,
    input  wire logic [2:0]  dec_xsp,
    input  wire logic [31:0] alu_dout,
    input  wire logic [31:0] ram_dout,
    input  wire logic     data_sel,
    input  wire wr_size_t alu_we,
    input  wire wr_size_t ram_we,
    input  wire logic     flag_only,
    input  wire logic     ld_high,
    input  wire logic [7:0]  dmp_addr,
    input  wire logic [15:0] sr,
    output logic [31:0]   src_out,
    output logic [31:0]   aux_out,
    output logic [31:0]   dst_out,
    output logic [31:0]   acc,
    output logic [31:0]   xsp,
    output logic          bc_unity,
    output logic [7:0]    dmp_din
);

    localparam int RFP_W     = $clog2(`REGS_BANKS);
    localparam int GEN_BYTES = `REGS_BANKS * `REGS_BANK_BYTES;
    localparam int PTR_BYTES = `REGS_PTR_BYTES;

    logic [7:0] gen_q [0:GEN_BYTES-1];
    logic [7:0] ptr_q [0:PTR_BYTES-1];

    logic [RFP_W-1:0] bank;
    reg_code_t        r0_code;
    reg_code_t        r1_code;
    logic [31:0]      step_val;
    logic [31:0]      r0_next;
    logic [15:0]      cur_bc;
    logic [15:0]      bc_next;
    logic [31:0]      cur_xde;
    logic [31:0]      xde_next;
    logic [31:0]      xix;
    logic [31:0]      xix_next;
    logic [31:0]      xsp_next;
    logic [31:0]      wdata;
    wr_size_t         we;
    logic [7:0]       dmp_next;

    // little endian read, lowest byte from the exact code
    function automatic logic [31:0] read_code(input reg_code_t c);
        logic [31:0] v;
        if (c[7]) begin
            v = {ptr_q[{c[3:2], 2'd3}], ptr_q[{c[3:2], 2'd2}],
                 ptr_q[{c[3:1], 1'b1}], ptr_q[c[3:0]]};
        end else begin
            v = {gen_q[{c[5:2], 2'd3}], gen_q[{c[5:2], 2'd2}],
                 gen_q[{c[5:1], 1'b1}], gen_q[c[5:0]]};
        end
        return v;
    endfunction

    assign bank    = sel.rfp;
    assign r0_code = sel.r0_sel;
    assign r1_code = sel.r1_sel;

    assign step_val = step_amount(reg_step);

    // current bank registers
    assign acc     = {gen_q[{bank, 4'd3}], gen_q[{bank, 4'd2}],
                      gen_q[{bank, 4'd1}], gen_q[{bank, 4'd0}]};
    assign cur_bc  = {gen_q[{bank, 4'd5}], gen_q[{bank, 4'd4}]};
    assign cur_xde = {gen_q[{bank, 4'hb}], gen_q[{bank, 4'ha}],
                      gen_q[{bank, 4'h9}], gen_q[{bank, 4'h8}]};
    assign xix     = {ptr_q[3], ptr_q[2], ptr_q[1], ptr_q[0]};
    assign xsp     = {ptr_q[15], ptr_q[14], ptr_q[13], ptr_q[12]};

    // auto-step always works on the aligned long
    assign r0_next  = reg_dec ? read_code({r0_code[7:2], 2'b00}) - step_val
                              : read_code({r0_code[7:2], 2'b00}) + step_val;
    assign bc_next  = cur_bc - 16'd1;
    assign xde_next = inc_xde ? cur_xde + step_val : cur_xde - step_val;
    assign xix_next = inc_xix ? xix + step_val : xix - step_val;
    assign xsp_next = (inc_xsp != 16'd0) ? xsp + {16'd0, inc_xsp}
                                         : xsp - {29'd0, dec_xsp};

    assign wdata = data_sel ? ram_dout : alu_dout;
    assign we    = flag_only ? 3'd0 : (data_sel ? ram_we : alu_we);

    always_comb begin
        // nibble 4 is a zero source
        src_out = (r0_code[7:4] == 4'h4) ? 32'd0 : read_code(r0_code);
        aux_out = (sel.aux_sel[7:4] == 4'h4) ? 32'd0 : read_code(sel.aux_sel);
        // pre-decrement view for block transfers
        dst_out = read_code(r1_code) - (reg_dec ? step_val : 32'd0);
    end

    // later statements override earlier ones on the same byte
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < GEN_BYTES; i++) begin
                gen_q[i] <= 8'd0;
            end
            for (int i = 0; i < PTR_BYTES; i++) begin
                ptr_q[i] <= 8'd0;
            end
            bc_unity <= 1'b0;
        end else if (cen) begin
            bc_unity <= (cur_bc == 16'd1);

            if (reg_inc || reg_dec) begin
                for (int i = 0; i < 4; i++) begin
                    if (r0_code[7]) begin
                        ptr_q[{r0_code[3:2], 2'(i)}] <= r0_next[8*i +: 8];
                    end else begin
                        gen_q[{r0_code[5:2], 2'(i)}] <= r0_next[8*i +: 8];
                    end
                end
            end

            if (dec_bc) begin
                gen_q[{bank, 4'd4}] <= bc_next[7:0];
                gen_q[{bank, 4'd5}] <= bc_next[15:8];
            end

            // LDI/LDD pointer pair
            if (inc_xde || dec_xde) begin
                for (int i = 0; i < 4; i++) begin
                    gen_q[{bank, 2'b10, 2'(i)}] <= xde_next[8*i +: 8];
                end
            end
            if (inc_xix || dec_xix) begin
                for (int i = 0; i < 4; i++) begin
                    ptr_q[i] <= xix_next[8*i +: 8];
                end
            end

            if (inc_xsp != 16'd0 || dec_xsp != 3'd0) begin
                for (int i = 0; i < 4; i++) begin
                    ptr_q[12 + i] <= xsp_next[8*i +: 8];
                end
            end

            // write-back, byte then word then long
            if (we[0]) begin
                if (r1_code[7]) begin
                    ptr_q[r1_code[3:0]] <= wdata[7:0];
                end else begin
                    // RLD/RRD take the upper byte
                    gen_q[r1_code[5:0]] <= ld_high ? wdata[15:8] : wdata[7:0];
                end
            end
            if (we[1]) begin
                if (r1_code[7]) begin
                    ptr_q[r1_code[3:0]]          <= wdata[7:0];
                    ptr_q[{r1_code[3:1], 1'b1}] <= wdata[15:8];
                end else begin
                    gen_q[r1_code[5:0]]          <= wdata[7:0];
                    gen_q[{r1_code[5:1], 1'b1}] <= wdata[15:8];
                end
            end
            if (we[2]) begin
                for (int i = 0; i < 4; i++) begin
                    if (r1_code[7]) begin
                        ptr_q[{r1_code[3:2], 2'(i)}] <= wdata[8*i +: 8];
                    end else begin
                        gen_q[{r1_code[5:2], 2'(i)}] <= wdata[8*i +: 8];
                    end
                end
            end
        end
    end

    // dump map: general, pointers, then status register
    always_comb begin
        if (dmp_addr < 8'h40) begin
            dmp_next = gen_q[dmp_addr[5:0]];
        end else if (dmp_addr < 8'h50) begin
            dmp_next = ptr_q[dmp_addr[3:0]];
        end else if (dmp_addr == 8'h50) begin
            dmp_next = sr[15:8];
        end else if (dmp_addr == 8'h51) begin
            dmp_next = sr[7:0];
        end else begin
            dmp_next = 8'd0;
        end
    end

    // debug path runs even while the core is stalled
    always_ff @(posedge clk) begin
        dmp_din <= dmp_next;
    end

endmodule

`default_nettype wire

/* rtl/bank_decode.sv */
// register file pointer and bank-relative code resolution
`timescale 1ns/1ps
`default_nettype none
`include "regs_params.svh"

module bank_decode import regs_pkg::*; (
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire logic                           cen,
    input  wire logic                           inc_rfp,
    input  wire logic                           dec_rfp,
    input  wire logic                           rfp_we,
    input  wire logic [$clog2(`REGS_BANKS)-1:0] imm,
    input  wire logic                           idx_en,
    input  wire reg_code_t                      src,
    input  wire reg_code_t                      dst,
    input  wire reg_code_t                      idx_rdreg_sel,
    input  wire reg_code_t                      idx_rdreg_aux,
    reg_sel_if.decoder                          sel,
    output logic      [$clog2(`REGS_BANKS)-1:0] rfp
);

    localparam int RFP_W = $clog2(`REGS_BANKS);

    logic [RFP_W-1:0] prev_bank;
    reg_code_t        idx_sel_res;

    // turn alias nibbles into a physical bank number
    function automatic reg_code_t resolve(
        input reg_code_t        code,
        input logic [RFP_W-1:0] cur,
        input logic [RFP_W-1:0] prev
    );
        reg_code_t res;
        res = code;
        if (code[7:4] == `REGS_CURBANK) begin
            res[7:4] = {{(4-RFP_W){1'b0}}, cur};
        end else if (code[7:4] == `REGS_PREVBANK) begin
            res[7:4] = {{(4-RFP_W){1'b0}}, prev};
        end
        return res;
    endfunction

    // wraps from bank 0 to the last bank
    assign prev_bank = rfp - 1'b1;

    // load beats decrement, decrement beats increment
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rfp <= '0;
        end else if (cen) begin
            if (rfp_we) begin
                rfp <= imm;
            end else if (dec_rfp) begin
                rfp <= rfp - 1'b1;
            end else if (inc_rfp) begin
                rfp <= rfp + 1'b1;
            end
        end
    end

    assign idx_sel_res = resolve(idx_rdreg_sel, rfp, prev_bank);

    assign sel.rfp     = rfp;
    // index addressing takes over both operand selects
    assign sel.r0_sel  = idx_en ? idx_sel_res : resolve(src, rfp, prev_bank);
    assign sel.r1_sel  = idx_en ? resolve(idx_rdreg_aux, rfp, prev_bank)
                                : resolve(dst, rfp, prev_bank);
    // LDD style pair, second register sits four bytes below
    assign sel.aux_sel = idx_sel_res & ~8'h04;

endmodule

`default_nettype wire

/* rtl/reg_sel_if.sv */
// resolved register selects passed from the bank decoder to the array
`timescale 1ns/1ps
`default_nettype none
`include "regs_params.svh"

interface reg_sel_if import regs_pkg::*; ();

    localparam int RFP_W = $clog2(`REGS_BANKS);

    // current bank pointer
    logic [RFP_W-1:0] rfp;
    // source side select, also the auto-step target
    reg_code_t r0_sel;
    // destination side select, also the write-back target
    reg_code_t r1_sel;
    // second index register, bit 2 cleared
    reg_code_t aux_sel;

    modport decoder (
        output rfp, r0_sel, r1_sel, aux_sel
    );

    modport array (
        input rfp, r0_sel, r1_sel, aux_sel
    );

endinterface

`default_nettype wire

/* rtl/regs_pkg.sv */
// register file types and step helper shared by design and testbench
`default_nettype none

package regs_pkg;

    // upper nibble picks bank, pointer space or bank alias
    typedef logic [7:0] reg_code_t;

    // bit 0 byte, bit 1 word, bit 2 long
    typedef logic [2:0] wr_size_t;

    // auto-step size code used by block transfers
    typedef logic [1:0] step_t;

    function automatic logic [31:0] step_amount(input step_t code);
        logic [31:0] amount;
        case (code)
            2'd1: amount = 32'd2;
            2'd2: amount = 32'd4;
            default: amount = 32'd1;
        endcase
        return amount;
    endfunction

endpackage

`default_nettype wire

/* rtl/regs_params.svh */
// register file sizing constants and bank-relative code values
`ifndef REGS_PARAMS_SVH
`define REGS_PARAMS_SVH

// general banks, each with XWA, XBC, XDE and XHL
`define REGS_BANKS 4

// bytes per general bank
`define REGS_BANK_BYTES 16

// XIX, XIY, XIZ and XSP bytes
`define REGS_PTR_BYTES 16

// upper nibble codes for the current and the previous bank
`define REGS_CURBANK 4'hE
`define REGS_PREVBANK 4'hD

`endif
